//--- dv/rx_dcore_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rx_dcore_chk #(
	parameter bit HOST_SIDE = 1'b0	// host port checks instead of arbiter checks
) (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire logic cap_req_i,
	input wire logic hst_gnt_i,
	input wire logic mem_we_i,
	input wire logic host_ack_i
);

	int fail_cnt = 0;	// failed assertions so far

	generate
		if (HOST_SIDE) begin : g_host
			a_ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
				host_ack_i |=> !host_ack_i)
				else begin
					fail_cnt++;
					$error("host ack longer than one cycle");
				end
		end else begin : g_arb
			// capture owns the memory port whenever it asks
			a_gnt_vs_cap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
				!(hst_gnt_i && cap_req_i))
				else begin
					fail_cnt++;
					$error("host grant in a capture cycle");
				end

			a_we_cap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
				mem_we_i |-> cap_req_i)
				else begin
					fail_cnt++;
					$error("memory write without capture request");
				end
		end
	endgenerate

endmodule

bind mem_arbiter rx_dcore_chk #(.HOST_SIDE(1'b0)) i_arb_chk (
	.clk_i     (clk_adc_i),
	.rst_n_i   (rst_n_i),
	.cap_req_i (cap_req_i),
	.hst_gnt_i (hst_gnt_o),
	.mem_we_i  (mem_we_o),
	.host_ack_i(1'b0)
);

bind host_regs rx_dcore_chk #(.HOST_SIDE(1'b1)) i_host_chk (
	.clk_i     (clk_adc_i),
	.rst_n_i   (rst_n_i),
	.cap_req_i (1'b0),
	.hst_gnt_i (1'b0),
	.mem_we_i  (1'b0),
	.host_ack_i(host_ack_o)
);

`default_nettype wire

//--- dv/rx_dcore_stimulus.txt
# F mag0 mag1 mag2 mag3 signs(lane3..0) count(dec) | I count(dec) | D dump start | A wait done
# W addr wdata | R addr expect mask | M addr (expect from dump copy) | P pi code, all hex
# after reset
P 20
R 0 00000000 ffffffff
R 2 00000020 0001003f
# loop on, gain 0, scripted transitions
W 0 00000001
R 0 00000001 ffffffff
F 40 10 20 05 a 3
F 12 7f 03 30 6 2
F 00 22 11 44 1 4
I 5
# one direction until the integrator clips
F 7f 00 00 00 c 400
P 3f
F 00 00 7f 00 c 600
P 00
# gain shift 3 scales the step
W 0 00000031
R 0 00000031 ffffffff
F 7f 00 00 00 c 100
I 4
# override and release
W 1 00000115
P 15
R 1 00000115 ffffffff
W 1 00000000
I 3
# dump then read back
D
A
R 2 00010000 00010000
M 0
M 1
M 7
M f
# read while a capture runs
D
M 3
M 9
R 2 00010000 00010000

//--- dv/rx_dcore_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_dcore_tb;

	localparam int NTI     = 4;
	localparam int NADC    = 7;	// as set inside rx_dcore
	localparam int NPI     = 6;
	localparam int DEPTH   = 16;
	localparam int ADC_W   = NTI * NADC;
	localparam int TIMEOUT = 200;

	logic                clk = 1'b0;
	logic                rst_n;
	logic [ADC_W-1:0]    adc;
	logic [NTI-1:0]      sgn;
	logic                dump_start;
	dcore_pkg::host_op_e host_op;
	logic [3:0]          host_addr;
	logic [31:0]         host_wdata;
	logic [NPI-1:0]      pi_ctl;
	logic                host_ack;
	logic [31:0]         host_rdata;
	logic                dump_done;

	// reference model state
	int          acc_m;
	int          err_m;
	logic        sign_prev_m;
	logic        cdr_en_m;
	int          gain_m;
	logic        ovr_en_m;
	int          ovr_val_m;
	logic        cap_active_m;
	int          cap_addr_m;
	logic        done_m;
	logic [31:0] mem_m [DEPTH];	// copy of the dumped frames
	logic        pend_wr;	// register write waiting for its ack
	logic [3:0]  pend_addr;
	logic [31:0] pend_data;

	int   errors;
	int   timeouts;
	logic stop;

	rx_dcore i_rx_dcore (
		.clk_adc_i       (clk),
		.rst_n_i         (rst_n),
		.adcout_i        (adc),
		.adcout_sign_i   (sgn),
		.ext_dump_start_i(dump_start),
		.host_op_i       (host_op),
		.host_addr_i     (host_addr),
		.host_wdata_i    (host_wdata),
		.pi_ctl_o        (pi_ctl),
		.host_ack_o      (host_ack),
		.host_rdata_o    (host_rdata),
		.dump_done_o     (dump_done)
	);

	always #50 clk = ~clk;

	task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERR at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	// offset binary code from the integrator or the override value
	function automatic logic [31:0] pi_model();
		if (ovr_en_m)
			return ovr_val_m;
		return (acc_m + 32768) >> (16 - NPI);
	endfunction

	function automatic logic [31:0] frame_word();
		logic [31:0] w;
		for (int i = 0; i < NTI; i++)
			w[i*(NADC+1) +: NADC+1] = {sgn[i], adc[i*NADC +: NADC]};
		return w;
	endfunction

	// one clock edge of the reference model with inputs as they stand at the edge
	task automatic model_edge();
		int   err;
		int   m;
		logic prev;
		if (!rst_n) begin
			acc_m        = 0;
			err_m        = 0;
			sign_prev_m  = 1'b0;
			cdr_en_m     = 1'b0;
			gain_m       = 0;
			ovr_en_m     = 1'b0;
			ovr_val_m    = 0;
			cap_active_m = 1'b0;
			cap_addr_m   = 0;
			done_m       = 1'b0;
		end else begin
			if (cdr_en_m) begin
				acc_m = acc_m + (err_m >>> gain_m);	// error of the previous frame
				if (acc_m > 32767)
					acc_m = 32767;
				else if (acc_m < -32768)
					acc_m = -32768;
			end
			err  = 0;
			prev = sign_prev_m;
			for (int i = 0; i < NTI; i++) begin
				m = adc[i*NADC +: NADC];
				if (sgn[i] != prev)
					err = sgn[i] ? err - m : err + m;
				prev = sgn[i];
			end
			err_m       = err;
			sign_prev_m = sgn[NTI-1];
			if (cap_active_m) begin
				mem_m[cap_addr_m] = frame_word();
				if (cap_addr_m == DEPTH - 1) begin
					cap_active_m = 1'b0;
					done_m       = 1'b1;
				end
				cap_addr_m++;
			end else if (dump_start) begin
				cap_active_m = 1'b1;
				cap_addr_m   = 0;
				done_m       = 1'b0;
			end
		end
	endtask

	// model follows the edge and outputs are checked 10 ns later where inputs get driven
	task automatic next_cycle();
		@(posedge clk);
		model_edge();
		#10;
		if (rst_n) begin
			if (host_ack && pend_wr) begin
				case (pend_addr[1:0])
					dcore_pkg::REG_CTRL: begin
						cdr_en_m = pend_data[0];
						gain_m   = pend_data[7:4];
					end
					dcore_pkg::REG_PI_OVR: begin
						ovr_en_m  = pend_data[8];
						ovr_val_m = pend_data[NPI-1:0];
					end
					default: ;
				endcase
				pend_wr = 1'b0;
			end
			compare(pi_ctl, pi_model(), "pi_ctl_o against loop model");
			compare(dump_done, done_m, "dump_done_o");
		end
	endtask

	task automatic tick_idle();
		adc = ADC_W'($urandom());	// filler frame
		sgn = NTI'($urandom());
		next_cycle();
	endtask

	task automatic host_cmd(input dcore_pkg::host_op_e op, input logic [3:0] addr,
		input logic [31:0] wdata, output int cycles);
		host_op    = op;
		host_addr  = addr;
		host_wdata = wdata;
		if (op == dcore_pkg::HOST_WR_REG) begin
			pend_wr   = 1'b1;
			pend_addr = addr;
			pend_data = wdata;
		end
		tick_idle();	// command edge
		host_op = dcore_pkg::HOST_NOP;
		cycles  = 1;
		while (!host_ack && cycles <= TIMEOUT) begin
			tick_idle();
			cycles++;
		end
		if (!host_ack) begin
			$display("timeout: host_ack_o did not pulse within %0d cycles", TIMEOUT);
			timeouts++;
			stop = 1'b1;
		end
	endtask

	initial begin
		int    fd;
		int    a;
		int    b;
		int    c;
		int    d;
		int    e;
		int    rep;
		int    cycles;
		int    chk_fails;
		logic  was_active;
		string line;
		string kind;
		void'($urandom(32'hc297_4876));
		rst_n      = 1'b0;
		adc        = '0;
		sgn        = '0;
		dump_start = 1'b0;
		host_op    = dcore_pkg::HOST_NOP;
		host_addr  = '0;
		host_wdata = '0;
		pend_wr    = 1'b0;
		errors     = 0;
		timeouts   = 0;
		stop       = 1'b0;
		repeat (4) next_cycle();
		rst_n = 1'b1;

		fd = $fopen("dv/rx_dcore_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file dv/rx_dcore_stimulus.txt");
			errors++;
			stop = 1'b1;
		end
		while (!stop && !$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				continue;
			if ($sscanf(line, "%s", kind) != 1)
				continue;	// blank line
			case (kind)
				"#": ;
				"F": begin
					void'($sscanf(line, "%s %h %h %h %h %h %d", kind, a, b, c, d, e, rep));
					adc = {NADC'(d), NADC'(c), NADC'(b), NADC'(a)};
					sgn = NTI'(e);
					repeat (rep) next_cycle();
				end
				"I": begin
					void'($sscanf(line, "%s %d", kind, rep));
					repeat (rep) tick_idle();
				end
				"D": begin
					dump_start = 1'b1;
					tick_idle();
					dump_start = 1'b0;
				end
				"A": begin
					cycles = 0;
					while (!dump_done && cycles < TIMEOUT) begin
						tick_idle();
						cycles++;
					end
					if (!dump_done) begin
						$display("timeout: dump_done_o did not rise within %0d cycles", TIMEOUT);
						timeouts++;
						stop = 1'b1;
					end
				end
				"W": begin
					void'($sscanf(line, "%s %h %h", kind, a, b));
					host_cmd(dcore_pkg::HOST_WR_REG, 4'(a), b, cycles);
					if (!stop)
						compare(cycles, 2, "register write latency");
				end
				"R": begin
					void'($sscanf(line, "%s %h %h %h", kind, a, b, c));
					host_cmd(dcore_pkg::HOST_RD_REG, 4'(a), 32'h0, cycles);
					if (!stop) begin
						compare(host_rdata & c, b & c, "register read data");
						compare(cycles, 2, "register read latency");
					end
				end
				"M": begin
					void'($sscanf(line, "%s %h", kind, a));
					was_active = cap_active_m;
					host_cmd(dcore_pkg::HOST_RD_MEM, 4'(a), 32'h0, cycles);
					if (!stop) begin
						compare(host_rdata, mem_m[a], "memory read data");
						compare(cycles >= 3, 1, "memory read latency below 3");
						if (was_active)
							compare(dump_done, 1'b1, "memory read ack before capture end");
					end
				end
				"P": begin
					void'($sscanf(line, "%s %h", kind, a));
					compare(pi_ctl, a, "pi_ctl_o expected code");
				end
				default: begin
					$display("unknown line in stimulus file: %s", line);
					errors++;
				end
			endcase
		end
		if (fd != 0)
			$fclose(fd);

		chk_fails = i_rx_dcore.i_mem_arbiter.i_arb_chk.fail_cnt
			+ i_rx_dcore.i_host_regs.i_host_chk.fail_cnt;
		$display("errors %0d, timeouts %0d, assertion failures %0d",
			errors, timeouts, chk_fails);
		if (errors == 0 && timeouts == 0 && chk_fails == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
verilog/dcore_pkg.sv
verilog/cdr_loop.sv
verilog/dump_capture.sv
verilog/host_regs.sv
verilog/mem_arbiter.sv
verilog/sample_ram.sv
verilog/rx_dcore.sv
dv/rx_dcore_chk.sv
dv/rx_dcore_tb.sv

//--- verilog/cdr_loop.sv
`timescale 1ns/1ps
`default_nettype none

module cdr_loop #(
	parameter int NTI   = dcore_pkg::NTI,
	parameter int NADC  = dcore_pkg::NADC,
	parameter int NPI   = dcore_pkg::NPI,
	parameter int ACC_W = dcore_pkg::ACC_W
) (
	input  wire logic                clk_adc_i,
	input  wire logic                rst_n_i,
	input  wire logic [NTI*NADC-1:0] adcout_i,
	input  wire logic [NTI-1:0]      adcout_sign_i,
	input  wire logic                cdr_en_i,
	input  wire logic [3:0]          gain_shift_i,
	input  wire logic                pi_ovr_en_i,
	input  wire logic [NPI-1:0]      pi_ovr_val_i,
	output logic      [NPI-1:0]      pi_ctl_o
);

	// room for NTI magnitudes of either sign
	localparam int ERR_W = NADC + $clog2(NTI) + 1;
	localparam logic signed [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
	localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

	logic                    sign_prev_q;	// lane NTI-1 of the last frame
	logic signed [ERR_W-1:0] err_d;
	logic signed [ERR_W-1:0] err_q;
	logic signed [ERR_W-1:0] step;
	logic signed [ACC_W:0]   sum;
	logic signed [ACC_W-1:0] acc_q;

	// stage 1: phase error from sign transitions across the frame
	always_comb begin
		logic                    prev_sgn;
		logic signed [ERR_W-1:0] mag;
		err_d = '0;
		for (int i = 0; i < NTI; i++) begin
			prev_sgn = (i == 0) ? sign_prev_q : adcout_sign_i[(i == 0) ? 0 : i-1];
			mag = $signed({{(ERR_W-NADC){1'b0}}, adcout_i[i*NADC +: NADC]});
			if (adcout_sign_i[i] != prev_sgn) begin
				if (adcout_sign_i[i])
					err_d = err_d - mag;	// falling into negative
				else
					err_d = err_d + mag;
			end
		end
	end

	always_ff @(posedge clk_adc_i) begin
		if (!rst_n_i) begin
			sign_prev_q <= 1'b0;
			err_q       <= '0;
		end else begin
			sign_prev_q <= adcout_sign_i[NTI-1];
			err_q       <= err_d;
		end
	end

	// stage 2: loop gain and saturating integrator
	assign step = err_q >>> gain_shift_i;

	always_comb begin
		logic signed [ACC_W:0] acc_ext;
		logic signed [ACC_W:0] step_ext;
		acc_ext  = acc_q;	// sign extended
		step_ext = step;
		sum      = acc_ext + step_ext;
	end

	always_ff @(posedge clk_adc_i) begin
		if (!rst_n_i) begin
			acc_q <= '0;
		end else if (cdr_en_i) begin
			if (sum[ACC_W] != sum[ACC_W-1])
				acc_q <= sum[ACC_W] ? ACC_MIN : ACC_MAX;	// clip on overflow
			else
				acc_q <= sum[ACC_W-1:0];
		end
	end

	// offset binary code, zero integrator gives mid code
	assign pi_ctl_o = pi_ovr_en_i ? pi_ovr_val_i
		: {~acc_q[ACC_W-1], acc_q[ACC_W-2 -: NPI-1]};

endmodule

`default_nettype wire

//--- verilog/dcore_pkg.sv
`default_nettype none

package dcore_pkg;

	// datapath sizes, overridable per instance through module parameters
	localparam int NTI        = 4;	// interleaved lanes
	localparam int NADC       = 8;	// magnitude bits per lane
	localparam int NPI        = 6;	// phase interpolator code
	localparam int ACC_W      = 16;	// loop integrator
	localparam int DUMP_DEPTH = 16;	// frames per dump
	localparam int DUMP_AW    = $clog2(DUMP_DEPTH);
	localparam int FRAME_W    = NTI * (NADC + 1);	// sign above magnitude per lane

	typedef enum logic [1:0] {
		HOST_NOP    = 2'd0,
		HOST_RD_REG = 2'd1,
		HOST_WR_REG = 2'd2,
		HOST_RD_MEM = 2'd3
	} host_op_e;

	typedef enum logic [1:0] {
		REG_CTRL   = 2'd0,	// cdr_en, gain_shift
		REG_PI_OVR = 2'd1,	// override enable and code
		REG_STATUS = 2'd2	// read only
	} reg_addr_e;

	typedef enum logic [1:0] {
		CAP_IDLE  = 2'd0,
		CAP_WRITE = 2'd1,
		CAP_DONE  = 2'd2
	} cap_state_e;

	typedef enum logic [1:0] {
		HOST_IDLE     = 2'd0,
		HOST_MEM_WAIT = 2'd1,
		HOST_ACK      = 2'd2
	} host_state_e;

endpackage

`default_nettype wire

//--- verilog/dump_capture.sv
`timescale 1ns/1ps
`default_nettype none

module dump_capture #(
	parameter int NTI        = dcore_pkg::NTI,
	parameter int NADC       = dcore_pkg::NADC,
	parameter int DUMP_DEPTH = dcore_pkg::DUMP_DEPTH,
	localparam int DUMP_AW   = $clog2(DUMP_DEPTH),
	localparam int FRAME_W   = NTI * (NADC + 1)
) (
	input  wire logic                clk_adc_i,
	input  wire logic                rst_n_i,
	input  wire logic                dump_start_i,
	input  wire logic [NTI*NADC-1:0] adcout_i,
	input  wire logic [NTI-1:0]      adcout_sign_i,
	output logic                     cap_req_o,
	output logic      [DUMP_AW-1:0]  cap_addr_o,
	output logic      [FRAME_W-1:0]  cap_wdata_o,
	output logic                     dump_done_o
);

	localparam logic [DUMP_AW-1:0] LAST_ADDR = DUMP_AW'(DUMP_DEPTH - 1);

	dcore_pkg::cap_state_e state_q;
	logic [DUMP_AW-1:0]    addr_q;

	always_ff @(posedge clk_adc_i) begin
		if (!rst_n_i) begin
			state_q <= dcore_pkg::CAP_IDLE;
			addr_q  <= '0;
		end else begin
			case (state_q)
				dcore_pkg::CAP_WRITE: begin
					// one frame per cycle, start pulses ignored here
					if (addr_q == LAST_ADDR)
						state_q <= dcore_pkg::CAP_DONE;
					addr_q <= addr_q + 1'b1;
				end
				default: begin	// idle or done
					if (dump_start_i) begin
						state_q <= dcore_pkg::CAP_WRITE;
						addr_q  <= '0;
					end
				end
			endcase
		end
	end

	// lane i field holds {sign, magnitude}, lane 0 lowest
	genvar i;
	generate
		for (i = 0; i < NTI; i++) begin : g_pack
			assign cap_wdata_o[i*(NADC+1) +: NADC+1] =
				{adcout_sign_i[i], adcout_i[i*NADC +: NADC]};
		end
	endgenerate

	assign cap_req_o   = (state_q == dcore_pkg::CAP_WRITE);
	assign cap_addr_o  = addr_q;
	assign dump_done_o = (state_q == dcore_pkg::CAP_DONE);	// held until next start

endmodule

`default_nettype wire

//--- verilog/host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module host_regs #(
	parameter int NTI        = dcore_pkg::NTI,
	parameter int NADC       = dcore_pkg::NADC,
	parameter int NPI        = dcore_pkg::NPI,
	parameter int DUMP_DEPTH = dcore_pkg::DUMP_DEPTH,
	localparam int DUMP_AW   = $clog2(DUMP_DEPTH),
	localparam int FRAME_W   = NTI * (NADC + 1)
) (
	input  wire logic                clk_adc_i,
	input  wire logic                rst_n_i,
	input  wire dcore_pkg::host_op_e host_op_i,
	input  wire logic [DUMP_AW-1:0]  host_addr_i,
	input  wire logic [31:0]         host_wdata_i,
	output logic                     host_ack_o,
	output logic      [31:0]         host_rdata_o,
	output logic                     hst_req_o,
	output logic      [DUMP_AW-1:0]  hst_addr_o,
	input  wire logic                hst_gnt_i,
	input  wire logic [FRAME_W-1:0]  mem_rdata_i,
	input  wire logic                dump_done_i,
	input  wire logic [NPI-1:0]      pi_ctl_i,
	output logic                     cdr_en_o,
	output logic      [3:0]          gain_shift_o,
	output logic                     pi_ovr_en_o,
	output logic      [NPI-1:0]      pi_ovr_val_o
);

	dcore_pkg::host_state_e state_q;
	dcore_pkg::host_op_e    op_q;
	dcore_pkg::reg_addr_e   reg_sel;
	logic [DUMP_AW-1:0]     addr_q;
	logic [31:0]            wdata_q;
	logic [31:0]            reg_rdata;

	assign reg_sel = dcore_pkg::reg_addr_e'(addr_q[1:0]);	// low bits pick the register

	always_comb begin
		reg_rdata = '0;
		case (reg_sel)
			dcore_pkg::REG_CTRL: begin
				reg_rdata[0]   = cdr_en_o;
				reg_rdata[7:4] = gain_shift_o;
			end
			dcore_pkg::REG_PI_OVR: begin
				reg_rdata[8]       = pi_ovr_en_o;
				reg_rdata[NPI-1:0] = pi_ovr_val_o;
			end
			dcore_pkg::REG_STATUS: begin
				reg_rdata[16]      = dump_done_i;
				reg_rdata[NPI-1:0] = pi_ctl_i;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_adc_i) begin
		if (!rst_n_i) begin
			state_q      <= dcore_pkg::HOST_IDLE;
			host_ack_o   <= 1'b0;
			cdr_en_o     <= 1'b0;
			gain_shift_o <= '0;
			pi_ovr_en_o  <= 1'b0;
			pi_ovr_val_o <= '0;
		end else begin
			host_ack_o <= 1'b0;
			case (state_q)
				dcore_pkg::HOST_IDLE: begin
					if (host_op_i == dcore_pkg::HOST_RD_MEM)
						state_q <= dcore_pkg::HOST_MEM_WAIT;
					else if (host_op_i != dcore_pkg::HOST_NOP)
						state_q <= dcore_pkg::HOST_ACK;
				end
				dcore_pkg::HOST_MEM_WAIT: begin
					if (hst_gnt_i)	// read data lands next cycle
						state_q <= dcore_pkg::HOST_ACK;
				end
				dcore_pkg::HOST_ACK: begin
					if (op_q == dcore_pkg::HOST_WR_REG) begin
						if (reg_sel == dcore_pkg::REG_CTRL) begin
							cdr_en_o     <= wdata_q[0];
							gain_shift_o <= wdata_q[7:4];
						end else if (reg_sel == dcore_pkg::REG_PI_OVR) begin
							pi_ovr_en_o  <= wdata_q[8];
							pi_ovr_val_o <= wdata_q[NPI-1:0];
						end
					end
					host_ack_o <= 1'b1;
					state_q    <= dcore_pkg::HOST_IDLE;
				end
				default: state_q <= dcore_pkg::HOST_IDLE;
			endcase
		end
	end

	// command capture and read data
	always_ff @(posedge clk_adc_i) begin
		if (state_q == dcore_pkg::HOST_IDLE) begin
			op_q    <= host_op_i;
			addr_q  <= host_addr_i;
			wdata_q <= host_wdata_i;
		end
		if (state_q == dcore_pkg::HOST_ACK)
			host_rdata_o <= (op_q == dcore_pkg::HOST_RD_MEM) ? 32'(mem_rdata_i) : reg_rdata;
	end

	assign hst_req_o  = (state_q == dcore_pkg::HOST_MEM_WAIT);
	assign hst_addr_o = addr_q;

endmodule

`default_nettype wire

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int NTI        = dcore_pkg::NTI,
	parameter int NADC       = dcore_pkg::NADC,
	parameter int DUMP_DEPTH = dcore_pkg::DUMP_DEPTH,
	localparam int DUMP_AW   = $clog2(DUMP_DEPTH),
	localparam int FRAME_W   = NTI * (NADC + 1)
) (
	input  wire logic               clk_adc_i,
	input  wire logic               rst_n_i,
	input  wire logic               cap_req_i,
	input  wire logic [DUMP_AW-1:0] cap_addr_i,
	input  wire logic [FRAME_W-1:0] cap_wdata_i,
	input  wire logic               hst_req_i,
	input  wire logic [DUMP_AW-1:0] hst_addr_i,
	output logic                    hst_gnt_o,
	output logic                    mem_en_o,
	output logic                    mem_we_o,
	output logic      [DUMP_AW-1:0] mem_addr_o,
	output logic      [FRAME_W-1:0] mem_wdata_o
);

	logic gnt_q;	// grant issued last cycle

	// capture always wins and never waits for a grant
	// host only gets a free cycle, and not twice in a row
	assign hst_gnt_o = hst_req_i & ~cap_req_i & ~gnt_q;

	always_ff @(posedge clk_adc_i) begin
		if (!rst_n_i)
			gnt_q <= 1'b0;
		else
			gnt_q <= hst_gnt_o;
	end

	assign mem_en_o    = cap_req_i | hst_gnt_o;
	assign mem_we_o    = cap_req_i;	// host side is read only
	assign mem_addr_o  = cap_req_i ? cap_addr_i : hst_addr_i;
	assign mem_wdata_o = cap_wdata_i;

endmodule

`default_nettype wire

//--- verilog/rx_dcore.sv
`timescale 1ns/1ps
`default_nettype none

module rx_dcore #(
	parameter int NTI        = dcore_pkg::NTI,
	parameter int NADC       = 7,	// keeps a stored frame within 32 bits
	parameter int NPI        = dcore_pkg::NPI,
	parameter int ACC_W      = dcore_pkg::ACC_W,
	parameter int DUMP_DEPTH = dcore_pkg::DUMP_DEPTH,
	localparam int DUMP_AW   = $clog2(DUMP_DEPTH),
	localparam int FRAME_W   = NTI * (NADC + 1)
) (
	input  wire logic                clk_adc_i,
	input  wire logic                rst_n_i,
	input  wire logic [NTI*NADC-1:0] adcout_i,
	input  wire logic [NTI-1:0]      adcout_sign_i,
	input  wire logic                ext_dump_start_i,
	input  wire dcore_pkg::host_op_e host_op_i,
	input  wire logic [DUMP_AW-1:0]  host_addr_i,
	input  wire logic [31:0]         host_wdata_i,
	output logic      [NPI-1:0]      pi_ctl_o,
	output logic                     host_ack_o,
	output logic      [31:0]         host_rdata_o,
	output logic                     dump_done_o
);

	// loop config from the register block
	logic               cdr_en;
	logic [3:0]         gain_shift;
	logic               pi_ovr_en;
	logic [NPI-1:0]     pi_ovr_val;

	// memory requesters
	logic               cap_req;
	logic [DUMP_AW-1:0] cap_addr;
	logic [FRAME_W-1:0] cap_wdata;
	logic               hst_req;
	logic [DUMP_AW-1:0] hst_addr;
	logic               hst_gnt;

	// memory port
	logic               mem_en;
	logic               mem_we;
	logic [DUMP_AW-1:0] mem_addr;
	logic [FRAME_W-1:0] mem_wdata;
	logic [FRAME_W-1:0] mem_rdata;

	cdr_loop #(.NTI(NTI), .NADC(NADC), .NPI(NPI), .ACC_W(ACC_W)) i_cdr_loop (
		.clk_adc_i    (clk_adc_i),
		.rst_n_i      (rst_n_i),
		.adcout_i     (adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.cdr_en_i     (cdr_en),
		.gain_shift_i (gain_shift),
		.pi_ovr_en_i  (pi_ovr_en),
		.pi_ovr_val_i (pi_ovr_val),
		.pi_ctl_o     (pi_ctl_o)
	);

	dump_capture #(.NTI(NTI), .NADC(NADC), .DUMP_DEPTH(DUMP_DEPTH)) i_dump_capture (
		.clk_adc_i    (clk_adc_i),
		.rst_n_i      (rst_n_i),
		.dump_start_i (ext_dump_start_i),
		.adcout_i     (adcout_i),
		.adcout_sign_i(adcout_sign_i),
		.cap_req_o    (cap_req),
		.cap_addr_o   (cap_addr),
		.cap_wdata_o  (cap_wdata),
		.dump_done_o  (dump_done_o)	// also status for the host
	);

	host_regs #(.NTI(NTI), .NADC(NADC), .NPI(NPI), .DUMP_DEPTH(DUMP_DEPTH)) i_host_regs (
		.clk_adc_i   (clk_adc_i),
		.rst_n_i     (rst_n_i),
		.host_op_i   (host_op_i),
		.host_addr_i (host_addr_i),
		.host_wdata_i(host_wdata_i),
		.host_ack_o  (host_ack_o),
		.host_rdata_o(host_rdata_o),
		.hst_req_o   (hst_req),
		.hst_addr_o  (hst_addr),
		.hst_gnt_i   (hst_gnt),
		.mem_rdata_i (mem_rdata),
		.dump_done_i (dump_done_o),
		.pi_ctl_i    (pi_ctl_o),
		.cdr_en_o    (cdr_en),
		.gain_shift_o(gain_shift),
		.pi_ovr_en_o (pi_ovr_en),
		.pi_ovr_val_o(pi_ovr_val)
	);

	mem_arbiter #(.NTI(NTI), .NADC(NADC), .DUMP_DEPTH(DUMP_DEPTH)) i_mem_arbiter (
		.clk_adc_i  (clk_adc_i),
		.rst_n_i    (rst_n_i),
		.cap_req_i  (cap_req),
		.cap_addr_i (cap_addr),
		.cap_wdata_i(cap_wdata),
		.hst_req_i  (hst_req),
		.hst_addr_i (hst_addr),
		.hst_gnt_o  (hst_gnt),
		.mem_en_o   (mem_en),
		.mem_we_o   (mem_we),
		.mem_addr_o (mem_addr),
		.mem_wdata_o(mem_wdata)
	);

	sample_ram #(.DUMP_DEPTH(DUMP_DEPTH), .FRAME_W(FRAME_W)) i_sample_ram (
		.clk_adc_i(clk_adc_i),
		.en_i     (mem_en),
		.we_i     (mem_we),
		.addr_i   (mem_addr),
		.wdata_i  (mem_wdata),
		.rdata_o  (mem_rdata)
	);

endmodule

`default_nettype wire

//--- verilog/sample_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sample_ram #(
	parameter int DUMP_DEPTH = dcore_pkg::DUMP_DEPTH,
	parameter int FRAME_W    = dcore_pkg::FRAME_W,
	localparam int DUMP_AW   = $clog2(DUMP_DEPTH)
) (
	input  wire logic               clk_adc_i,
	input  wire logic               en_i,
	input  wire logic               we_i,
	input  wire logic [DUMP_AW-1:0] addr_i,
	input  wire logic [FRAME_W-1:0] wdata_i,
	output logic      [FRAME_W-1:0] rdata_o
);

	logic [FRAME_W-1:0] mem [DUMP_DEPTH];

	// single port, read data one cycle after the access
	always_ff @(posedge clk_adc_i) begin
		if (en_i) begin
			if (we_i)
				mem[addr_i] <= wdata_i;
			else
				rdata_o <= mem[addr_i];
		end
	end

endmodule

`default_nettype wire
